// ==== Bender.yml ====
package:
  name: agu_dual

sources:
  - agu_pkg.sv
  - agu_issue_fifo.sv
  - agu_lane_arbiter.sv
  - agu_store_encoder.sv
  - agu_dual.sv
  - target: test
    files:
      - agu_dual_asserts.sv
      - tb_agu_dual.sv

// ==== agu_dual.sv ====
// dual-issue rv32 load/store agu top, connects lane arbiter, issue fifo and bus encoder
`timescale 1ns/1ps

module agu_dual
    import agu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     lane1_valid_i,
    input  agu_req_t lane1_req_i,
    input  logic     lane2_valid_i,
    input  agu_req_t lane2_req_i,
    input  logic     lsu_stall_i,
    output logic     mem_req_o,
    output agu_cmd_t mem_cmd_o,
    output logic     misaligned_load_o,
    output logic     misaligned_store_o,
    output logic     atom_lock_o,
    output logic     stall_req_o
);
    logic     push;
    logic     push_double;
    logic     pop;
    agu_req_t push_first;
    agu_req_t push_second;
    agu_req_t head;
    logic     fifo_empty;
    logic     fifo_full;
    logic     fifo_two_free;
    logic     out_valid;
    agu_req_t out_req;

    agu_lane_arbiter #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) arbiter_i (
        .lane1_valid_i(lane1_valid_i),
        .lane2_valid_i(lane2_valid_i),
        .lane1_req_i  (lane1_req_i),
        .lane2_req_i  (lane2_req_i),
        .lsu_stall_i  (lsu_stall_i),
        .head_i       (head),
        .empty_i      (fifo_empty),
        .full_i       (fifo_full),
        .two_free_i   (fifo_two_free),
        .push_o       (push),
        .push_double_o(push_double),
        .pop_o        (pop),
        .push_first_o (push_first),
        .push_second_o(push_second),
        .out_valid_o  (out_valid),
        .out_req_o    (out_req),
        .stall_req_o  (stall_req_o)
    );

    agu_issue_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .T         (agu_req_t)
    ) fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_double_i(push_double),
        .push_first_i (push_first),
        .push_second_i(push_second),
        .pop_i        (pop),
        .head_o       (head),
        .empty_o      (fifo_empty),
        .full_o       (fifo_full),
        .two_free_o   (fifo_two_free)
    );

    agu_store_encoder encoder_i (
        .out_valid_i       (out_valid),
        .out_req_i         (out_req),
        .mem_req_o         (mem_req_o),
        .mem_cmd_o         (mem_cmd_o),
        .misaligned_load_o (misaligned_load_o),
        .misaligned_store_o(misaligned_store_o)
    );

    // lock held while anything is queued
    assign atom_lock_o = ~fifo_empty;

endmodule

// ==== agu_dual_asserts.sv ====
// concurrent checks on the agu top level, bound into agu_dual from the testbench
`timescale 1ns/1ps

module agu_dual_asserts
    import agu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     lane1_valid_i,
    input agu_req_t lane1_req_i,
    input logic     lane2_valid_i,
    input agu_req_t lane2_req_i,
    input logic     stall_req_i,
    input agu_cmd_t mem_cmd_i,
    input logic     misaligned_load_i,
    input logic     misaligned_store_i,
    input logic     atom_lock_i
);
    logic any_live;
    logic cmd_is_store;

    assign any_live = (lane1_valid_i && (lane1_req_i.op != MEM_NONE)) ||
                      (lane2_valid_i && (lane2_req_i.op != MEM_NONE));
    assign cmd_is_store = is_store(mem_cmd_i.op);

    // upstream is only held back when it offered something
    stall_needs_live_a: assert property (
        @(posedge clk) disable iff (!rst_n) stall_req_i |-> any_live
    ) else $error("stall_req_o high while no lane is live");

    no_mask_without_store_a: assert property (
        @(posedge clk) disable iff (!rst_n) !cmd_is_store |-> (mem_cmd_i.wmask == '0)
    ) else $error("mem_cmd_o.wmask nonzero for a non-store op");

    // queue comes out of reset empty
    lock_low_after_reset_a: assert property (
        @(posedge clk) $rose(rst_n) |-> !atom_lock_i
    ) else $error("atom_lock_o high right after reset release");

    one_misalign_flag_a: assert property (
        @(posedge clk) disable iff (!rst_n) !(misaligned_load_i && misaligned_store_i)
    ) else $error("both misaligned flags high in the same cycle");

endmodule

// ==== agu_issue_fifo.sv ====
// in-order issue queue with one or two pushes and one pop per cycle, payload set by type parameter
`timescale 1ns/1ps

module agu_issue_fifo
    import agu_pkg::*;
#(
    parameter int  FIFO_DEPTH = 4,
    parameter type T          = agu_req_t
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,
    input  logic push_double_i,
    input  T     push_first_i,
    input  T     push_second_i,
    input  logic pop_i,
    output T     head_o,
    output logic empty_o,
    output logic full_o,
    output logic two_free_o
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] tail_next;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;
    logic [1:0]       push_cnt;

    // pointer advance with wrap at the depth, not only at powers of two
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr,
                                                  input int unsigned step);
        int unsigned sum;
        sum = ptr + step;
        if (sum >= FIFO_DEPTH) begin
            sum = sum - FIFO_DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == CNT_W'(FIFO_DEPTH));
    assign two_free_o = ((int'(count_q) + 2) <= FIFO_DEPTH);
    assign head_o     = mem_q[head_q];

    // a double push needs two slots, a single push one
    assign do_push  = push_i && (push_double_i ? two_free_o : !full_o);
    assign do_pop   = pop_i && !empty_o;
    assign push_cnt = !do_push ? 2'd0 : (push_double_i ? 2'd2 : 2'd1);

    assign tail_next = ptr_step(tail_q, 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_pop) begin
                head_q <= ptr_step(head_q, 1);
            end
            if (do_push) begin
                tail_q <= ptr_step(tail_q, push_cnt);
            end
            // net change covers push and pop in the same cycle
            count_q <= count_q + CNT_W'(push_cnt) - CNT_W'(do_pop);
        end
    end

    // first entry lands at the tail, the second right behind it
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[tail_q] <= push_first_i;
            if (push_double_i) begin
                mem_q[tail_next] <= push_second_i;
            end
        end
    end

endmodule

// ==== agu_lane_arbiter.sv ====
// per-cycle decision for two lanes: what goes out, what is queued, and when to stall upstream
`timescale 1ns/1ps

module agu_lane_arbiter
    import agu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     lane1_valid_i,
    input  logic     lane2_valid_i,
    input  agu_req_t lane1_req_i,
    input  agu_req_t lane2_req_i,
    input  logic     lsu_stall_i,
    input  agu_req_t head_i,
    input  logic     empty_i,
    input  logic     full_i,
    input  logic     two_free_i,
    output logic     push_o,
    output logic     push_double_o,
    output logic     pop_o,
    output agu_req_t push_first_o,
    output agu_req_t push_second_o,
    output logic     out_valid_o,
    output agu_req_t out_req_o,
    output logic     stall_req_o
);
    // a depth-one queue can never take a lane pair
    localparam bit CAN_DOUBLE = (FIFO_DEPTH >= 2);

    logic     live1;
    logic     live2;
    logic     both_live;
    logic     one_live;
    logic     same_type;
    logic     direct;
    agu_req_t direct_req;
    agu_req_t single_req;

    assign live1     = lane1_valid_i && (lane1_req_i.op != MEM_NONE);
    assign live2     = lane2_valid_i && (lane2_req_i.op != MEM_NONE);
    assign both_live = live1 && live2;
    assign one_live  = live1 ^ live2;
    assign same_type = both_live &&
                       ((is_load(lane1_req_i.op) && is_load(lane2_req_i.op)) ||
                        (is_store(lane1_req_i.op) && is_store(lane2_req_i.op)));

    // the only live lane when just one is live
    assign single_req = live1 ? lane1_req_i : lane2_req_i;

    always_comb begin
        push_o        = 1'b0;
        push_double_o = 1'b0;
        pop_o         = 1'b0;
        stall_req_o   = 1'b0;
        direct        = 1'b0;
        direct_req    = lane1_req_i;
        push_first_o  = lane2_req_i;
        push_second_o = lane2_req_i;

        if (both_live) begin
            if (full_i) begin
                stall_req_o = 1'b1;
                pop_o       = !lsu_stall_i;
            end else if (same_type && empty_i) begin
                // lane 1 bypasses, lane 2 waits its turn
                direct = 1'b1;
                push_o = 1'b1;
            end else if (same_type) begin
                if (two_free_i && CAN_DOUBLE) begin
                    push_o        = 1'b1;
                    push_double_o = 1'b1;
                    push_first_o  = lane1_req_i;
                    pop_o         = !lsu_stall_i;
                end else begin
                    stall_req_o = 1'b1;
                    pop_o       = !lsu_stall_i;
                end
            end else begin
                // mixed load/store pair, lane 1 leaves now
                direct = 1'b1;
                push_o = 1'b1;
            end
        end else if (one_live) begin
            if (empty_i) begin
                direct     = 1'b1;
                direct_req = single_req;
            end else if (!full_i) begin
                push_o       = 1'b1;
                push_first_o = single_req;
                pop_o        = !lsu_stall_i;
            end else begin
                stall_req_o = 1'b1;
                pop_o       = !lsu_stall_i;
            end
        end else begin
            // idle lanes, drain the queue
            pop_o = !lsu_stall_i && !empty_i;
        end
    end

    // popped head wins over a bypassing lane
    assign out_valid_o = pop_o || direct;
    assign out_req_o   = pop_o ? head_i : direct_req;

endmodule

// ==== agu_pkg.sv ====
// shared widths, memory op encoding and request/command structs for the dual-issue agu
package agu_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int BUS_W       = 64;
    localparam int BUS_BYTES   = BUS_W / 8;
    localparam int COMMIT_ID_W = 4;
    localparam int REG_ADDR_W  = 5;

    // compact memory op carried by each lane
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // one lane request, also the fifo payload
    typedef struct packed {
        logic [XLEN-1:0]        rs1;
        logic [XLEN-1:0]        rs2;
        logic [XLEN-1:0]        imm;
        mem_op_e                op;
        logic [COMMIT_ID_W-1:0] commit_id;
        logic [REG_ADDR_W-1:0]  rd;
    } agu_req_t;

    // encoded request on the 64-bit memory port
    typedef struct packed {
        logic [XLEN-1:0]        addr;
        logic [BUS_BYTES-1:0]   wmask;
        logic [BUS_W-1:0]       wdata;
        mem_op_e                op;
        logic [COMMIT_ID_W-1:0] commit_id;
        logic [REG_ADDR_W-1:0]  rd;
    } agu_cmd_t;

    function automatic logic is_load(input mem_op_e op);
        logic res;
        case (op)
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU: res = 1'b1;
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    function automatic logic is_store(input mem_op_e op);
        logic res;
        case (op)
            MEM_SB, MEM_SH, MEM_SW: res = 1'b1;
            default: res = 1'b0;
        endcase
        return res;
    endfunction

endpackage

// ==== agu_stimulus.txt ====
# l1 valid op rs1 rs2 imm cid rd, l2 valid op rs1 rs2 imm cid rd, lsu_stall (all hex)
# expected: mem_req addr wmask wdata op cid rd mis_ld mis_st stall_req atom_lock
1 6 1000 123456a5 0 1 0  0 0 0 0 0 0 0  0  1 1000 01 a5 6 1 0 0 0 0 0
1 6 1000 123456a5 1 2 0  0 0 0 0 0 0 0  0  1 1001 02 a500 6 2 0 0 0 0 0
1 6 1001 123456a5 1 3 0  0 0 0 0 0 0 0  0  1 1002 04 a50000 6 3 0 0 0 0 0
1 6 1003 123456a5 0 4 0  0 0 0 0 0 0 0  0  1 1003 08 a5000000 6 4 0 0 0 0 0
1 6 1000 123456a5 4 5 0  0 0 0 0 0 0 0  0  1 1004 10 a500000000 6 5 0 0 0 0 0
1 6 1006 123456a5 ffffffff 6 0  0 0 0 0 0 0 0  0  1 1005 20 a50000000000 6 6 0 0 0 0 0
1 6 1000 123456a5 6 7 0  0 0 0 0 0 0 0  0  1 1006 40 a5000000000000 6 7 0 0 0 0 0
1 6 1008 123456a5 ffffffff 8 0  0 0 0 0 0 0 0  0  1 1007 80 a500000000000000 6 8 0 0 0 0 0
1 7 1000 1234beef 0 9 0  0 0 0 0 0 0 0  0  1 1000 03 beef 7 9 0 0 0 0 0
1 7 1000 1234beef 2 a 0  0 0 0 0 0 0 0  0  1 1002 0c beef0000 7 a 0 0 0 0 0
1 7 1000 1234beef 4 b 0  0 0 0 0 0 0 0  0  1 1004 30 beef00000000 7 b 0 0 0 0 0
1 7 1010 1234beef fffffff6 c 0  0 0 0 0 0 0 0  0  1 1006 c0 beef000000000000 7 c 0 0 0 0 0
1 8 1000 cafef00d 0 d 0  0 0 0 0 0 0 0  0  1 1000 0f cafef00d 8 d 0 0 0 0 0
1 8 1000 cafef00d 4 e 0  0 0 0 0 0 0 0  0  1 1004 f0 cafef00d00000000 8 e 0 0 0 0 0
0 0 0 0 0 0 0  1 8 2000 55aa55aa 4 f 9  0  1 2004 f0 55aa55aa00000000 8 f 9 0 0 0 0
1 0 1000 0 0 0 0  0 0 0 0 0 0 0  0  0 0 00 0 0 0 0 0 0 0 0
1 3 1000 ffffffff 2 1 1  0 0 0 0 0 0 0  0  1 1002 00 0 3 1 1 1 0 0 0
1 3 1000 0 1 2 2  0 0 0 0 0 0 0  0  1 1001 00 0 3 2 2 1 0 0 0
1 2 1000 0 3 3 3  0 0 0 0 0 0 0  0  1 1003 00 0 2 3 3 1 0 0 0
1 5 1000 0 5 4 4  0 0 0 0 0 0 0  0  1 1005 00 0 5 4 4 1 0 0 0
1 8 1000 cafef00d 6 5 0  0 0 0 0 0 0 0  0  1 1006 f0 cafef00d00000000 8 5 0 0 1 0 0
1 7 1000 1234beef 1 6 0  0 0 0 0 0 0 0  0  1 1001 03 beef 7 6 0 0 1 0 0
1 1 1000 ffffffff 3 7 5  0 0 0 0 0 0 0  0  1 1003 00 0 1 7 5 0 0 0 0
1 4 1000 0 7 8 6  0 0 0 0 0 0 0  0  1 1007 00 0 4 8 6 0 0 0 0
1 2 1000 0 2 9 7  0 0 0 0 0 0 0  0  1 1002 00 0 2 9 7 0 0 0 0
1 3 1000 0 4 a 8  0 0 0 0 0 0 0  0  1 1004 00 0 3 a 8 0 0 0 0
1 3 2000 0 0 1 3  1 3 2000 0 4 2 4  0  1 2000 00 0 3 1 3 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 2004 00 0 3 2 4 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  0 0 00 0 0 0 0 0 0 0 0
1 8 3000 11223344 8 3 0  1 1 3000 0 1 4 5  0  1 3008 0f 11223344 8 3 0 0 0 0 0
1 4 3000 0 2 5 6  0 0 0 0 0 0 0  0  1 3001 00 0 1 4 5 0 0 0 1
1 6 3000 77 3 6 0  1 7 3000 abcd 6 7 0  0  1 3002 00 0 4 5 6 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 3003 08 77000000 6 6 0 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 3006 c0 abcd000000000000 7 7 0 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  0 0 00 0 0 0 0 0 0 0 0
1 3 4000 0 0 8 1  1 3 4000 0 4 9 2  1  1 4000 00 0 3 8 1 0 0 0 0
1 2 4000 0 8 a 3  1 5 4000 0 a b 4  1  0 0 00 0 0 0 0 0 0 0 1
1 1 4000 0 c c 5  0 0 0 0 0 0 0  1  0 0 00 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0  1 6 4000 5a 10 d 0  1  0 0 00 0 0 0 0 0 0 1 1
0 0 0 0 0 0 0  1 6 4000 5a 10 d 0  0  1 4004 00 0 3 9 2 0 0 1 1
0 0 0 0 0 0 0  1 6 4000 5a 10 d 0  0  1 4008 00 0 2 a 3 0 0 0 1
1 4 4000 0 e e 6  1 1 4000 0 f f 7  1  0 0 00 0 0 0 0 0 0 1 1
1 4 4000 0 e e 6  1 1 4000 0 f f 7  1  0 0 00 0 0 0 0 0 0 1 1
1 4 4000 0 e e 6  1 1 4000 0 f f 7  0  1 400a 00 0 5 b 4 0 0 1 1
1 4 4000 0 e e 6  1 1 4000 0 f f 7  0  1 400c 00 0 1 c 5 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 4010 01 5a 6 d 0 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  1  0 0 00 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 400e 00 0 4 e 6 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  1 400f 00 0 1 f 7 0 0 0 1
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0  0 0 00 0 0 0 0 0 0 0 0

// ==== agu_store_encoder.sv ====
// turns the outgoing request into a 64-bit bus command with address, byte mask and placed data
`timescale 1ns/1ps

module agu_store_encoder
    import agu_pkg::*;
(
    input  logic     out_valid_i,
    input  agu_req_t out_req_i,
    output logic     mem_req_o,
    output agu_cmd_t mem_cmd_o,
    output logic     misaligned_load_o,
    output logic     misaligned_store_o
);
    logic [XLEN-1:0]      addr;
    logic [2:0]           byte_off;
    logic [BUS_BYTES-1:0] wmask;
    logic [BUS_W-1:0]     wdata;
    logic                 word_misaligned;
    logic                 half_misaligned;

    assign addr     = out_req_i.rs1 + out_req_i.imm;
    assign byte_off = addr[2:0];

    // byte lane placement inside the bus word
    always_comb begin
        wmask = '0;
        wdata = '0;
        if (out_valid_i) begin
            case (out_req_i.op)
                MEM_SB: begin
                    wmask = BUS_BYTES'(1'b1) << byte_off;
                    wdata = BUS_W'(out_req_i.rs2[7:0]) << {byte_off, 3'b000};
                end
                MEM_SH: begin
                    wmask = BUS_BYTES'(2'b11) << {byte_off[2:1], 1'b0};
                    wdata = BUS_W'(out_req_i.rs2[15:0]) << {byte_off[2:1], 4'b0000};
                end
                MEM_SW: begin
                    wmask = BUS_BYTES'(4'hf) << {byte_off[2], 2'b00};
                    wdata = BUS_W'(out_req_i.rs2) << {byte_off[2], 5'b00000};
                end
                default: begin
                    // loads carry no write data
                end
            endcase
        end
    end

    // word ops need a 4-byte boundary, half ops an even address
    assign word_misaligned = (addr[1:0] != 2'b00);
    assign half_misaligned = addr[0];

    assign misaligned_load_o = out_valid_i &&
        (((out_req_i.op == MEM_LW) && word_misaligned) ||
         (((out_req_i.op == MEM_LH) || (out_req_i.op == MEM_LHU)) && half_misaligned));

    assign misaligned_store_o = out_valid_i &&
        (((out_req_i.op == MEM_SW) && word_misaligned) ||
         ((out_req_i.op == MEM_SH) && half_misaligned));

    assign mem_req_o = out_valid_i;

    // command is zero on idle cycles
    always_comb begin
        mem_cmd_o = '0;
        if (out_valid_i) begin
            mem_cmd_o.addr      = addr;
            mem_cmd_o.wmask     = wmask;
            mem_cmd_o.wdata     = wdata;
            mem_cmd_o.op        = out_req_i.op;
            mem_cmd_o.commit_id = out_req_i.commit_id;
            mem_cmd_o.rd        = out_req_i.rd;
        end
    end

endmodule

// ==== src.f ====
agu_pkg.sv
agu_issue_fifo.sv
agu_lane_arbiter.sv
agu_store_encoder.sv
agu_dual.sv
agu_dual_asserts.sv
tb_agu_dual.sv

// ==== tb_agu_dual.sv ====
// testbench for the dual-issue agu that replays agu_stimulus.txt one cycle per line and checks outputs
`timescale 1ns/1ps

module tb_agu_dual
    import agu_pkg::*;
();
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_LEAD  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 41486;

    // one stimulus line with inputs first and expected outputs after
    typedef struct packed {
        logic     lane1_valid;
        agu_req_t lane1_req;
        logic     lane2_valid;
        agu_req_t lane2_req;
        logic     lsu_stall;
        logic     exp_req;
        agu_cmd_t exp_cmd;
        logic     exp_mis_ld;
        logic     exp_mis_st;
        logic     exp_stall;
        logic     exp_lock;
    } vector_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     lane1_valid;
    agu_req_t lane1_req;
    logic     lane2_valid;
    agu_req_t lane2_req;
    logic     lsu_stall;
    logic     mem_req;
    agu_cmd_t mem_cmd;
    logic     misaligned_load;
    logic     misaligned_store;
    logic     atom_lock;
    logic     stall_req;

    vector_t  vectors[$];
    bit       loaded = 1'b0;
    int       cmd_errs = 0;
    int       op_errs = 0;
    int       bit_errs = 0;
    int       other_errs = 0;

    agu_dual #(
        .FIFO_DEPTH(4)
    ) dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .lane1_valid_i     (lane1_valid),
        .lane1_req_i       (lane1_req),
        .lane2_valid_i     (lane2_valid),
        .lane2_req_i       (lane2_req),
        .lsu_stall_i       (lsu_stall),
        .mem_req_o         (mem_req),
        .mem_cmd_o         (mem_cmd),
        .misaligned_load_o (misaligned_load),
        .misaligned_store_o(misaligned_store),
        .atom_lock_o       (atom_lock),
        .stall_req_o       (stall_req)
    );

    bind agu_dual agu_dual_asserts asserts_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .lane1_valid_i     (lane1_valid_i),
        .lane1_req_i       (lane1_req_i),
        .lane2_valid_i     (lane2_valid_i),
        .lane2_req_i       (lane2_req_i),
        .stall_req_i       (stall_req_o),
        .mem_cmd_i         (mem_cmd_o),
        .misaligned_load_i (misaligned_load_o),
        .misaligned_store_i(misaligned_store_o),
        .atom_lock_i       (atom_lock_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // lane fields from base on are op, rs1, rs2, imm, commit id and rd
    function automatic agu_req_t make_req(input logic [63:0] f [26], input int base);
        agu_req_t r;
        r.op        = mem_op_e'(f[base][3:0]);
        r.rs1       = f[base + 1][XLEN-1:0];
        r.rs2       = f[base + 2][XLEN-1:0];
        r.imm       = f[base + 3][XLEN-1:0];
        r.commit_id = f[base + 4][COMMIT_ID_W-1:0];
        r.rd        = f[base + 5][REG_ADDR_W-1:0];
        return r;
    endfunction

    // payload of an idle lane is junk and must not matter
    function automatic agu_req_t random_req();
        agu_req_t r;
        r.rs1       = $urandom;
        r.rs2       = $urandom;
        r.imm       = $urandom;
        r.op        = mem_op_e'($urandom_range(8, 0));
        r.commit_id = COMMIT_ID_W'($urandom);
        r.rd        = REG_ADDR_W'($urandom);
        return r;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [63:0] f [26];
        vector_t     v;
        fd = $fopen("agu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open agu_stimulus.txt for reading");
            other_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                        f[17], f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25]);
            if (n != 26) begin
                $display("stimulus line has %0d fields instead of 26: %s", n, line);
                other_errs++;
                continue;
            end
            v.lane1_valid       = f[0][0];
            v.lane1_req         = make_req(f, 1);
            v.lane2_valid       = f[7][0];
            v.lane2_req         = make_req(f, 8);
            v.lsu_stall         = f[14][0];
            v.exp_req           = f[15][0];
            v.exp_cmd.addr      = f[16][XLEN-1:0];
            v.exp_cmd.wmask     = f[17][BUS_BYTES-1:0];
            v.exp_cmd.wdata     = f[18][BUS_W-1:0];
            v.exp_cmd.op        = mem_op_e'(f[19][3:0]);
            v.exp_cmd.commit_id = f[20][COMMIT_ID_W-1:0];
            v.exp_cmd.rd        = f[21][REG_ADDR_W-1:0];
            v.exp_mis_ld        = f[22][0];
            v.exp_mis_st        = f[23][0];
            v.exp_stall         = f[24][0];
            v.exp_lock          = f[25][0];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input vector_t v);
        lane1_valid = v.lane1_valid;
        lane1_req   = v.lane1_valid ? v.lane1_req : random_req();
        lane2_valid = v.lane2_valid;
        lane2_req   = v.lane2_valid ? v.lane2_req : random_req();
        lsu_stall   = v.lsu_stall;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: time %0t signal %s expected %b got %b", $time, name, exp, act);
            bit_errs++;
        end
    endtask

    task automatic check_cmd(input string name, input agu_cmd_t exp, input agu_cmd_t act);
        if (act !== exp) begin
            $display("Error: time %0t signal %s expected %h got %h", $time, name, exp, act);
            cmd_errs++;
        end
    endtask

    task automatic check_op(input string name, input mem_op_e exp, input mem_op_e act);
        if (act !== exp) begin
            $display("Error: time %0t signal %s expected %s got %s",
                     $time, name, exp.name(), act.name());
            op_errs++;
        end
    endtask

    task automatic check_outputs(input vector_t v);
        check_bit("mem_req_o", v.exp_req, mem_req);
        check_cmd("mem_cmd_o", v.exp_cmd, mem_cmd);
        check_op("mem_cmd_o.op", v.exp_cmd.op, mem_cmd.op);
        check_bit("misaligned_load_o", v.exp_mis_ld, misaligned_load);
        check_bit("misaligned_store_o", v.exp_mis_st, misaligned_store);
        check_bit("stall_req_o", v.exp_stall, stall_req);
        check_bit("atom_lock_o", v.exp_lock, atom_lock);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        lane1_valid = 1'b0;
        lane1_req   = '0;
        lane2_valid = 1'b0;
        lane2_req   = '0;
        lsu_stall   = 1'b0;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no stimulus vectors were loaded");
            other_errs++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        // drive just after the edge, sample just before the next one
        foreach (vectors[i]) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_inputs(vectors[i]);
            #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
            check_outputs(vectors[i]);
        end
        $display("vectors %0d, errors: cmd %0d, op %0d, flag %0d, other %0d",
                 vectors.size(), cmd_errs, op_errs, bit_errs, other_errs);
        if (cmd_errs + op_errs + bit_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // reset plus every vector fits well inside this margin
    initial begin
        wait (loaded);
        #(CLK_PERIOD * (vectors.size() + 20));
        $display("watchdog expired before all stimulus vectors were applied");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
